//--- touch_display.f
+incdir+verilog
verilog/touch_display_pkg.sv
verilog/touchpad_controller.sv
verilog/touch_position_latch.sv
verilog/tft_timing.sv
verilog/backlight_pwm.sv
verilog/tft_driver.sv
verilog/touch_display.sv
tests/touchpad_model.sv
tests/touch_display_tb.sv

//--- Bender.yml
package:
  name: touch_display

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/touch_display_pkg.sv
      - verilog/touchpad_controller.sv
      - verilog/touch_position_latch.sv
      - verilog/tft_timing.sv
      - verilog/backlight_pwm.sv
      - verilog/tft_driver.sv
      - verilog/touch_display.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/touchpad_model.sv
      - tests/touch_display_tb.sv

//--- tests/touch_display_tb.sv
`timescale 1ns/1ps

`include "touch_display_consts.svh"

module touch_display_tb;

	localparam int frame_cycles = `TFT_H_TOTAL * `TFT_V_TOTAL * `TFT_PIX_DIV;
	// low cycles between two lines
	localparam int h_blank_cycles = (`TFT_H_TOTAL - `TFT_H_ACTIVE) * `TFT_PIX_DIV;
	localparam int pwm_cycles = `PWM_PERIOD + 1;
	// about six frames of scans plus pwm windows, one frame spare
	localparam int timeout_cycles = 7 * frame_cycles + 16 * pwm_cycles;

	logic cclk;
	logic arst_n;
	logic [7:0] switch;
	logic touch_busy;
	logic touch_data_out;
	logic touch_clk;
	logic touch_csb;
	logic touch_data_in;
	touch_display_pkg::rgb_t tft_rgb;
	logic tft_data_ena;
	logic tft_display;
	logic tft_vdd;
	logic tft_backlight;
	// digitizer readings
	logic [11:0] touch_x;
	logic [11:0] touch_y;
	logic [11:0] touch_z;
	touch_display_pkg::cursor_t last_cursor;
	int seed = 3;
	int errors = 0;
	int cycle_count = 0;

	touch_display touch_display_inst (
		.cclk           (cclk),
		.arst_n         (arst_n),
		.switch         (switch),
		.touch_busy     (touch_busy),
		.touch_data_out (touch_data_out),
		.touch_clk      (touch_clk),
		.touch_csb      (touch_csb),
		.touch_data_in  (touch_data_in),
		.tft_rgb        (tft_rgb),
		.tft_data_ena   (tft_data_ena),
		.tft_display    (tft_display),
		.tft_vdd        (tft_vdd),
		.tft_backlight  (tft_backlight)
	);

	touchpad_model touchpad_model_inst (
		.cclk           (cclk),
		.touch_clk      (touch_clk),
		.touch_csb      (touch_csb),
		.touch_data_in  (touch_data_in),
		.x_val          (touch_x),
		.y_val          (touch_y),
		.z_val          (touch_z),
		.touch_busy     (touch_busy),
		.touch_data_out (touch_data_out)
	);

	initial begin
		cclk = 1'b0;
		forever #2 cclk = ~cclk;
	end

	// run limit
	always @(posedge cclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: tests still running after %0d cclk cycles", cycle_count);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	task automatic fail_now(input string msg);
		errors++;
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("error at %0t ns: %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic compare_rgb(input string name, input touch_display_pkg::rgb_t got,
			input touch_display_pkg::rgb_t exp);
		if (got !== exp) begin
			fail_now($sformatf("error at %0t ns: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			fail_now($sformatf("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	// returns on the first enabled cycle after vertical blanking
	task automatic wait_frame_start();
		int low_run;
		low_run = 0;
		// line gaps are much shorter than the vertical blank
		while (low_run <= 2 * h_blank_cycles) begin
			@(negedge cclk);
			low_run = tft_data_ena ? 0 : low_run + 1;
		end
		while (!tft_data_ena) begin
			@(negedge cclk);
		end
	endtask

	// one frame, crosshair pixels and line geometry
	task automatic compare_cursor_pixel(input touch_display_pkg::cursor_t exp_cursor);
		int line;
		int run;
		int gap;
		int total;
		touch_display_pkg::rgb_t exp_px;
		line = 0;
		total = 0;
		wait_frame_start();
		// lines until a gap longer than the horizontal blank
		while (tft_data_ena) begin
			run = 0;
			while (tft_data_ena) begin
				// one check per pixel, on its first cclk
				if (run % `TFT_PIX_DIV == 0) begin
					if ((run / `TFT_PIX_DIV) == int'(exp_cursor.x) || line == int'(exp_cursor.y)) begin
						exp_px = 24'hFF_FF_FF;
					end else begin
						exp_px = 24'h00_00_00;
					end
					compare_rgb("tft_rgb", tft_rgb, exp_px);
					total++;
				end
				run++;
				@(negedge cclk);
			end
			compare_count("tft_data_ena cycles per line", run, `TFT_H_ACTIVE * `TFT_PIX_DIV);
			line++;
			gap = 0;
			while (!tft_data_ena && gap <= h_blank_cycles) begin
				gap++;
				@(negedge cclk);
			end
			if (tft_data_ena) begin
				compare_count("tft_data_ena gap between lines", gap, h_blank_cycles);
			end
		end
		compare_count("enabled pixels per frame", total, `TFT_H_ACTIVE * `TFT_V_ACTIVE);
	endtask

	task automatic set_touch(input logic [11:0] x, input logic [11:0] y, input logic [11:0] z);
		@(negedge cclk);
		touch_x = x;
		touch_y = y;
		touch_z = z;
	endtask

	task automatic check_idle_outputs();
		compare_bit("touch_csb", touch_csb, 1'b1);
		compare_bit("touch_clk", touch_clk, 1'b0);
		compare_bit("tft_data_ena", tft_data_ena, 1'b0);
		compare_bit("tft_backlight", tft_backlight, 1'b0);
	endtask

	task automatic check_reset_state();
		arst_n = 1'b0;
		repeat (4) begin
			@(negedge cclk);
			check_idle_outputs();
		end
		arst_n = 1'b1;
		// first cycle out of reset
		@(negedge cclk);
		check_idle_outputs();
		compare_bit("tft_display", tft_display, 1'b1);
		compare_bit("tft_vdd", tft_vdd, 1'b1);
	endtask

	task automatic check_frame_geometry();
		// nothing pressed yet, crosshair at the origin
		last_cursor = '0;
		compare_cursor_pixel(last_cursor);
	endtask

	task automatic check_firm_touch();
		int x;
		int y;
		x = `TOUCH_X_OFFSET + {$random(seed)} % (`TFT_H_ACTIVE << `TOUCH_SCALE_SHIFT);
		y = `TOUCH_Y_OFFSET + {$random(seed)} % (`TFT_V_ACTIVE << `TOUCH_SCALE_SHIFT);
		set_touch(12'(x), 12'(y), 12'h400);
		// counts to pixels
		last_cursor.x = 9'((x - `TOUCH_X_OFFSET) >> `TOUCH_SCALE_SHIFT);
		last_cursor.y = 9'((y - `TOUCH_Y_OFFSET) >> `TOUCH_SCALE_SHIFT);
		wait_frame_start();
		compare_cursor_pixel(last_cursor);
	endtask

	task automatic check_light_touch();
		int x;
		int y;
		x = `TOUCH_X_OFFSET + {$random(seed)} % (`TFT_H_ACTIVE << `TOUCH_SCALE_SHIFT);
		y = `TOUCH_Y_OFFSET + {$random(seed)} % (`TFT_V_ACTIVE << `TOUCH_SCALE_SHIFT);
		// below threshold, cursor must stay
		set_touch(12'(x), 12'(y), 12'h0FF);
		wait_frame_start();
		compare_cursor_pixel(last_cursor);
	endtask

	task automatic measure_backlight(input logic [7:0] duty);
		int high;
		high = 0;
		@(negedge cclk);
		switch = duty;
		// duty taken at the next wrap
		repeat (2 * pwm_cycles) @(negedge cclk);
		repeat (4 * pwm_cycles) begin
			@(negedge cclk);
			if (tft_backlight) begin
				high++;
			end
		end
		compare_count("tft_backlight high cycles", high, 4 * int'(duty));
	endtask

	task automatic check_backlight();
		measure_backlight(8'd64);
		measure_backlight(8'd0);
	endtask

	initial begin
		arst_n = 1'b0;
		switch = 8'd0;
		touch_x = 12'd0;
		touch_y = 12'd0;
		touch_z = 12'd0;
		check_reset_state();
		check_frame_geometry();
		check_firm_touch();
		check_light_touch();
		check_backlight();
		if (errors == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1);
		end
	end

endmodule

//--- tests/touchpad_model.sv
`timescale 1ns/1ps

`include "touch_display_consts.svh"

module touchpad_model (
	input  logic        cclk,
	input  logic        touch_clk,
	input  logic        touch_csb,
	input  logic        touch_data_in,
	input  logic [11:0] x_val,
	input  logic [11:0] y_val,
	input  logic [11:0] z_val,
	output logic        touch_busy,
	output logic        touch_data_out
);

	logic clk_q;
	// touch_clk rises seen in the current channel, 1 to 24
	logic [4:0] edge_cnt;
	logic [4:0] next_cnt;
	logic [7:0] cmd;
	logic [11:0] word;

	initial begin
		clk_q = 1'b0;
		edge_cnt = '0;
		cmd = '0;
		touch_busy = 1'b0;
		touch_data_out = 1'b0;
	end

	assign next_cnt = (edge_cnt == 5'd24) ? 5'd1 : edge_cnt + 5'd1;

	// channel picked by the last command byte
	always_comb begin
		case (cmd)
			`TOUCH_CMD_X: word = x_val;
			`TOUCH_CMD_Y: word = y_val;
			`TOUCH_CMD_Z: word = z_val;
			default: word = 12'd0;
		endcase
	end

	// touch_clk edges found on falling cclk, lines change there too
	always @(negedge cclk) begin
		clk_q <= touch_clk;
		if (touch_csb) begin
			// idle between rounds
			edge_cnt <= '0;
			touch_busy <= 1'b0;
			touch_data_out <= 1'b0;
		end else if (touch_clk && !clk_q) begin
			edge_cnt <= next_cnt;
			// command bits, msb first
			if (next_cnt <= 5'd8) begin
				cmd <= {cmd[6:0], touch_data_in};
			end
			// conversion busy for one period after the command
			touch_busy <= (next_cnt == 5'd8);
		end else if (!touch_clk && clk_q) begin
			// result bit for the next rise, msb after the busy period
			if (edge_cnt >= 5'd9 && edge_cnt <= 5'd20) begin
				touch_data_out <= word[5'd20 - edge_cnt];
			end else begin
				touch_data_out <= 1'b0;
			end
		end
	end

endmodule

//--- verilog/touch_display.sv
`timescale 1ns/1ps

module touch_display (
	input  logic                    cclk,
	input  logic                    arst_n,
	input  logic [7:0]              switch,
	// touchpad lines
	input  logic                    touch_busy,
	input  logic                    touch_data_out,
	output logic                    touch_clk,
	output logic                    touch_csb,
	output logic                    touch_data_in,
	// panel lines
	output touch_display_pkg::rgb_t tft_rgb,
	output logic                    tft_data_ena,
	output logic                    tft_display,
	output logic                    tft_vdd,
	output logic                    tft_backlight
);

	touch_display_pkg::touch_sample_t sample;
	logic sample_valid;
	logic new_frame;
	touch_display_pkg::cursor_t cursor;

	touchpad_controller touchpad_controller_inst (
		.cclk           (cclk),
		.arst_n         (arst_n),
		.touch_busy     (touch_busy),
		.touch_data_out (touch_data_out),
		.touch_clk      (touch_clk),
		.touch_csb      (touch_csb),
		.touch_data_in  (touch_data_in),
		.sample         (sample),
		.sample_valid   (sample_valid)
	);

	// calibrated cursor, frame synchronous
	touch_position_latch touch_position_latch_inst (
		.cclk         (cclk),
		.arst_n       (arst_n),
		.sample       (sample),
		.sample_valid (sample_valid),
		.new_frame    (new_frame),
		.cursor       (cursor)
	);

	// switches set the backlight duty
	tft_driver tft_driver_inst (
		.cclk          (cclk),
		.arst_n        (arst_n),
		.duty_cycle    (switch),
		.cursor        (cursor),
		.tft_rgb       (tft_rgb),
		.tft_data_ena  (tft_data_ena),
		.tft_display   (tft_display),
		.tft_vdd       (tft_vdd),
		.tft_backlight (tft_backlight),
		.new_frame     (new_frame)
	);

endmodule

//--- verilog/tft_driver.sv
`timescale 1ns/1ps

module tft_driver (
	input  logic                       cclk,
	input  logic                       arst_n,
	input  logic [7:0]                 duty_cycle,
	input  touch_display_pkg::cursor_t cursor,
	output touch_display_pkg::rgb_t    tft_rgb,
	output logic                       tft_data_ena,
	output logic                       tft_display,
	output logic                       tft_vdd,
	output logic                       tft_backlight,
	output logic                       new_frame
);

	logic pix_en;
	touch_display_pkg::pixel_pos_t pos;
	logic active;
	logic on_cursor;
	// panel power, up right after reset
	logic power_on;

	tft_timing tft_timing_inst (
		.cclk      (cclk),
		.arst_n    (arst_n),
		.pix_en    (pix_en),
		.pos       (pos),
		.active    (active),
		.new_frame (new_frame)
	);

	backlight_pwm backlight_pwm_inst (
		.cclk       (cclk),
		.arst_n     (arst_n),
		.duty_cycle (duty_cycle),
		.pwm        (tft_backlight)
	);

	// crosshair column or row
	assign on_cursor = active && ((pos.x == {1'b0, cursor.x}) || (pos.y == cursor.y));

	always_ff @(posedge cclk or negedge arst_n) begin
		if (!arst_n) begin
			tft_data_ena <= 1'b0;
			power_on <= 1'b0;
		end else begin
			power_on <= 1'b1;
			if (pix_en) begin
				tft_data_ena <= active;
			end
		end
	end

	// pixel data, same pixel as tft_data_ena
	always_ff @(posedge cclk) begin
		if (pix_en) begin
			tft_rgb <= on_cursor ? 24'hFF_FF_FF : 24'h00_00_00;
		end
	end

	assign tft_display = power_on;
	assign tft_vdd = power_on;

endmodule

//--- verilog/backlight_pwm.sv
`timescale 1ns/1ps

`include "touch_display_consts.svh"

module backlight_pwm (
	input  logic       cclk,
	input  logic       arst_n,
	input  logic [7:0] duty_cycle,
	output logic       pwm
);

	logic [7:0] cnt;
	// duty taken once per period
	logic [7:0] duty_q;
	logic wrap;

	assign wrap = (cnt == 8'(`PWM_PERIOD));

	always_ff @(posedge cclk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			duty_q <= '0;
			pwm <= 1'b0;
		end else begin
			if (wrap) begin
				cnt <= '0;
				duty_q <= duty_cycle;
			end else begin
				cnt <= cnt + 8'd1;
			end
			// high for the first duty_q counts
			pwm <= (cnt < duty_q);
		end
	end

endmodule

//--- verilog/tft_timing.sv
`timescale 1ns/1ps

`include "touch_display_consts.svh"

module tft_timing (
	input  logic                          cclk,
	input  logic                          arst_n,
	output logic                          pix_en,
	output touch_display_pkg::pixel_pos_t pos,
	output logic                          active,
	output logic                          new_frame
);

	logic [$clog2(`TFT_PIX_DIV)-1:0] div_cnt;
	logic line_end;
	logic frame_end;

	// one pixel every TFT_PIX_DIV cycles
	assign pix_en = (div_cnt == ($clog2(`TFT_PIX_DIV))'(`TFT_PIX_DIV - 1));
	assign line_end = (pos.x == 10'(`TFT_H_TOTAL - 1));
	assign frame_end = line_end && (pos.y == 9'(`TFT_V_TOTAL - 1));
	// visible area, blanking is the rest
	assign active = (pos.x < 10'(`TFT_H_ACTIVE)) && (pos.y < 9'(`TFT_V_ACTIVE));

	always_ff @(posedge cclk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
		end else if (pix_en) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge cclk or negedge arst_n) begin
		if (!arst_n) begin
			pos <= '0;
			new_frame <= 1'b0;
		end else begin
			// pulse lands with pos back at 0,0
			new_frame <= pix_en && frame_end;
			if (pix_en) begin
				if (line_end) begin
					pos.x <= '0;
					pos.y <= frame_end ? 9'd0 : pos.y + 9'd1;
				end else begin
					pos.x <= pos.x + 10'd1;
				end
			end
		end
	end

	a_frame_at_origin: assert property (
		@(posedge cclk) disable iff (!arst_n)
		new_frame |-> (pos == '0) && $past(pix_en)
	);

endmodule

//--- verilog/touch_position_latch.sv
`timescale 1ns/1ps

`include "touch_display_consts.svh"

module touch_position_latch (
	input  logic                             cclk,
	input  logic                             arst_n,
	input  touch_display_pkg::touch_sample_t sample,
	input  logic                             sample_valid,
	input  logic                             new_frame,
	output touch_display_pkg::cursor_t       cursor
);

	logic [11:0] x_adj;
	logic [11:0] y_adj;
	// calibrated position, waits for a frame boundary
	touch_display_pkg::cursor_t pending;
	logic pending_touch;

	// offsets wrap modulo 12 bits
	assign x_adj = sample.x - 12'(`TOUCH_X_OFFSET);
	assign y_adj = sample.y - 12'(`TOUCH_Y_OFFSET);

	always_ff @(posedge cclk) begin
		if (sample_valid) begin
			pending.x <= 9'(x_adj >> `TOUCH_SCALE_SHIFT);
			pending.y <= 9'(y_adj >> `TOUCH_SCALE_SHIFT);
		end
	end

	always_ff @(posedge cclk or negedge arst_n) begin
		if (!arst_n) begin
			pending_touch <= 1'b0;
			cursor <= '0;
		end else begin
			// pressure test, light touches keep the old cursor
			if (sample_valid) begin
				pending_touch <= ((sample.z >> `TOUCH_Z_SHIFT) != 12'd0);
			end
			// move only between frames so no tearing
			if (new_frame && pending_touch) begin
				cursor <= pending;
			end
		end
	end

	a_cursor_frame_sync: assert property (
		@(posedge cclk) disable iff (!arst_n)
		!$stable(cursor) |-> $past(new_frame)
	);

endmodule

//--- verilog/touchpad_controller.sv
`timescale 1ns/1ps

`include "touch_display_consts.svh"

module touchpad_controller (
	input  logic                             cclk,
	input  logic                             arst_n,
	input  logic                             touch_busy,
	input  logic                             touch_data_out,
	output logic                             touch_clk,
	output logic                             touch_csb,
	output logic                             touch_data_in,
	output touch_display_pkg::touch_sample_t sample,
	output logic                             sample_valid
);

	typedef enum logic [2:0] {ST_GAP, ST_CMD, ST_BUSY, ST_READ, ST_PAD} state_t;

	state_t state;
	logic [$clog2(`TOUCH_CLK_DIV)-1:0] div_cnt;
	logic half_tick;
	logic rise;
	logic fall;
	// bits or half periods, depending on state
	logic [3:0] bit_cnt;
	// 0 = x, 1 = y, 2 = z
	logic [1:0] ch;
	logic [7:0] cmd;
	logic [7:0] cmd_next;
	logic [11:0] shift;
	logic [11:0] result;
	logic [11:0] x_hold;
	logic [11:0] y_hold;

	function automatic logic [7:0] chan_cmd(input logic [1:0] c);
		case (c)
			2'd0: chan_cmd = `TOUCH_CMD_X;
			2'd1: chan_cmd = `TOUCH_CMD_Y;
			default: chan_cmd = `TOUCH_CMD_Z;
		endcase
	endfunction

	assign cmd = chan_cmd(ch);
	assign cmd_next = chan_cmd(ch + 2'd1);
	assign half_tick = (div_cnt == ($clog2(`TOUCH_CLK_DIV))'(`TOUCH_CLK_DIV - 1));
	// touch_clk only runs while csb is low
	assign rise = half_tick && (state != ST_GAP) && !touch_clk;
	assign fall = half_tick && touch_clk;
	assign result = {shift[10:0], touch_data_out};

	// free running half period divider
	always_ff @(posedge cclk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
		end else if (half_tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge cclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_GAP;
			touch_csb <= 1'b1;
			touch_clk <= 1'b0;
			touch_data_in <= 1'b0;
			bit_cnt <= '0;
			ch <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			if (half_tick && state == ST_GAP) begin
				// gap is 2 touch_clk periods, 4 half ticks
				if (bit_cnt == 4'd3) begin
					touch_csb <= 1'b0;
					state <= ST_CMD;
					bit_cnt <= '0;
					touch_data_in <= cmd[7];
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (half_tick) begin
				touch_clk <= ~touch_clk;
			end
			// last z bit in, publish on the next cycle
			if (rise && state == ST_READ && bit_cnt == 4'd11 && ch == 2'd2) begin
				sample_valid <= 1'b1;
			end
			// state steps on falling edges, end of each period
			if (fall) begin
				case (state)
					ST_CMD: begin
						if (bit_cnt == 4'd7) begin
							state <= ST_BUSY;
							bit_cnt <= '0;
							touch_data_in <= 1'b0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							// msb first
							touch_data_in <= cmd[3'd6 - bit_cnt[2:0]];
						end
					end
					ST_BUSY: begin
						// hold here until the conversion ends
						if (!touch_busy) begin
							state <= ST_READ;
							bit_cnt <= '0;
						end
					end
					ST_READ: begin
						if (bit_cnt == 4'd11) begin
							state <= ST_PAD;
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					ST_PAD: begin
						if (bit_cnt != 4'd2) begin
							bit_cnt <= bit_cnt + 1'b1;
						end else if (ch == 2'd2) begin
							// round done, csb up for the gap
							state <= ST_GAP;
							touch_csb <= 1'b1;
							ch <= '0;
							bit_cnt <= '0;
						end else begin
							ch <= ch + 2'd1;
							state <= ST_CMD;
							bit_cnt <= '0;
							touch_data_in <= cmd_next[7];
						end
					end
					default: state <= ST_GAP;
				endcase
			end
		end
	end

	// result shift register and per channel holds
	always_ff @(posedge cclk) begin
		if (rise && state == ST_READ) begin
			shift <= result;
			if (bit_cnt == 4'd11) begin
				case (ch)
					2'd0: x_hold <= result;
					2'd1: y_hold <= result;
					default: sample <= '{x: x_hold, y: y_hold, z: result};
				endcase
			end
		end
	end

	a_clk_quiet_when_idle: assert property (
		@(posedge cclk) disable iff (!arst_n)
		(touch_csb && $past(touch_csb)) |-> $stable(touch_clk)
	);

endmodule

//--- verilog/touch_display_pkg.sv
package touch_display_pkg;

	// one digitizer round, x in the top bits
	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
		// pressure channel
		logic [11:0] z;
	} touch_sample_t;

	// cursor in panel coordinates
	typedef struct packed {
		// column, 0 to 479
		logic [8:0] x;
		// row, 0 to 271
		logic [8:0] y;
	} cursor_t;

	// one panel pixel
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// current scan position, blanking included
	typedef struct packed {
		// counts up to TFT_H_TOTAL - 1
		logic [9:0] x;
		// counts up to TFT_V_TOTAL - 1
		logic [8:0] y;
	} pixel_pos_t;

endpackage

//--- verilog/touch_display_consts.svh
`ifndef TOUCH_DISPLAY_CONSTS_SVH
`define TOUCH_DISPLAY_CONSTS_SVH

// panel geometry, pixels and lines
`define TFT_H_ACTIVE 480
`define TFT_H_TOTAL 525
`define TFT_V_ACTIVE 272
`define TFT_V_TOTAL 286

// cclk cycles per panel pixel
`define TFT_PIX_DIV 4

// cclk cycles per half period of touch_clk
`define TOUCH_CLK_DIV 8

// digitizer commands, start bit and channel select
`define TOUCH_CMD_X 8'hD0
`define TOUCH_CMD_Y 8'h90
`define TOUCH_CMD_Z 8'hB0

// calibration, raw counts to pixels
`define TOUCH_X_OFFSET 150
`define TOUCH_Y_OFFSET 300
`define TOUCH_SCALE_SHIFT 3

// touch present when z >> shift is nonzero
`define TOUCH_Z_SHIFT 8

// backlight pwm counts minus one
`define PWM_PERIOD 255

`endif
